// File: mem_island_cfg_pkg.sv
//##########################################################
// Memory island geometry
// Data widths, bank counts, address field positions and the
// wide outstanding limit
//##########################################################
`default_nettype none

package mem_island_cfg_pkg;

   // Byte address width
   localparam int unsigned AddrWidth = 16;

   // Port data widths
   localparam int unsigned NarrowWidth = 32;
   localparam int unsigned WideWidth   = 64;

   // Narrow sub-banks that make up one wide bank
   localparam int unsigned SubBanksPerWide = WideWidth / NarrowWidth;
   localparam int unsigned NumWideBanks    = 2;

   // Little-endian address fields
   localparam int unsigned NarrowWordBit = $clog2(NarrowWidth / 8);
   localparam int unsigned WideWordBit   = $clog2(WideWidth / 8);
   // Wide bank select sits right above the wide word offset
   localparam int unsigned WideBankBit   = WideWordBit;
   localparam int unsigned RowBit        = WideBankBit + $clog2(NumWideBanks);
   localparam int unsigned MaxRowWidth   = AddrWidth - RowBit;

   // Wide responses in flight
   localparam int unsigned WideMaxOutstanding = 2;

endpackage

`default_nettype wire

// File: mem_island_bus_pkg.sv
//##########################################################
// Memory island bus types
// Port payloads, sub-bank requests and bank index types
//##########################################################
`default_nettype none

package mem_island_bus_pkg;

   typedef logic [mem_island_cfg_pkg::AddrWidth-1:0] addr_t;

   typedef logic [mem_island_cfg_pkg::NarrowWidth-1:0]   narrow_data_t;
   typedef logic [mem_island_cfg_pkg::NarrowWidth/8-1:0] narrow_strb_t;
   typedef logic [mem_island_cfg_pkg::WideWidth-1:0]     wide_data_t;
   typedef logic [mem_island_cfg_pkg::WideWidth/8-1:0]   wide_strb_t;

   // Only the low bits up to the bank depth are decoded
   typedef logic [mem_island_cfg_pkg::MaxRowWidth-1:0] row_t;

   typedef logic [$clog2(mem_island_cfg_pkg::NumWideBanks)-1:0]    wide_bank_idx_t;
   typedef logic [$clog2(mem_island_cfg_pkg::SubBanksPerWide)-1:0] sub_bank_idx_t;

   // Narrow port request
   typedef struct packed {
      addr_t        addr;
      logic         we;
      narrow_data_t wdata;
      narrow_strb_t strb;
   } narrow_req_t;

   // Wide port request
   typedef struct packed {
      addr_t      addr;
      logic       we;
      wide_data_t wdata;
      wide_strb_t strb;
   } wide_req_t;

   // Access to one 32-bit sub-bank, shared by narrow and wide sides
   typedef struct packed {
      row_t         row;
      logic         we;
      narrow_data_t wdata;
      narrow_strb_t strb;
   } bank_req_t;

endpackage

`default_nettype wire

// File: sram_bank.sv
//##########################################################
// SRAM sub-bank
// Single port, byte strobed writes, one cycle read latency
//##########################################################
`timescale 1ns/1ps
`default_nettype none

module sram_bank #(
   parameter int unsigned WordsPerBank = 64
) (
   input  wire logic                          clk_i,
   input  wire logic                          req_i,
   input  wire mem_island_bus_pkg::bank_req_t bank_i,
   output      mem_island_bus_pkg::narrow_data_t rdata_o
);
   import mem_island_bus_pkg::*;

   localparam int unsigned RowWidth = $clog2(WordsPerBank);

   narrow_data_t         mem_q [WordsPerBank];
   narrow_data_t         rdata_q;
   logic [RowWidth-1:0]  row_idx;

   // Upper row bits beyond the bank depth are ignored
   assign row_idx = bank_i.row[RowWidth-1:0];

   always_ff @(posedge clk_i) begin
      if (req_i) begin
         if (bank_i.we) begin
            for (int b = 0; b < $bits(narrow_strb_t); b++) begin
               if (bank_i.strb[b]) begin
                  mem_q[row_idx][8*b +: 8] <= bank_i.wdata[8*b +: 8];
               end
            end
         end else begin
            rdata_q <= mem_q[row_idx];
         end
      end
   end

   assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: bank_arbiter.sv
//##########################################################
// Sub-bank arbiter
// Narrow side wins by default, wide side gets a turn after
// WidePriorityWait contended cycles
//##########################################################
`timescale 1ns/1ps
`default_nettype none

module bank_arbiter #(
   parameter int unsigned WordsPerBank     = 64,
   parameter int unsigned WidePriorityWait = 1
) (
   input  wire logic                          clk_i,
   input  wire logic                          rst_ni,
   input  wire logic                          narrow_req_i,
   input  wire mem_island_bus_pkg::bank_req_t narrow_bank_i,
   output      logic                          narrow_gnt_o,
   input  wire logic                          wide_req_i,
   input  wire mem_island_bus_pkg::bank_req_t wide_bank_i,
   output      logic                          wide_gnt_o,
   output      logic                          wide_rvalid_o,
   output      mem_island_bus_pkg::narrow_data_t rdata_o
);
   import mem_island_bus_pkg::*;

   localparam int unsigned CntWidth =
      (WidePriorityWait > 0) ? $clog2(WidePriorityWait + 1) : 1;

   logic [CntWidth-1:0] wait_cnt_q, wait_cnt_d;
   logic                wide_turn;
   logic                wide_rvalid_q;
   logic                sram_req;
   bank_req_t           sram_bank_req;

   // Wide side takes this cycle once the wait count has run out
   assign wide_turn = (WidePriorityWait != 0) && wide_req_i &&
                      (wait_cnt_q == CntWidth'(WidePriorityWait));

   assign narrow_gnt_o = narrow_req_i & ~wide_turn;
   assign wide_gnt_o   = wide_req_i & ~narrow_gnt_o;

   // Count consecutive contended cycles lost by the wide side
   always_comb begin
      wait_cnt_d = '0;
      if ((WidePriorityWait != 0) && narrow_req_i && wide_req_i && !wide_turn) begin
         wait_cnt_d = wait_cnt_q + 1'b1;
      end
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         wait_cnt_q    <= '0;
         wide_rvalid_q <= 1'b0;
      end else begin
         wait_cnt_q    <= wait_cnt_d;
         wide_rvalid_q <= wide_gnt_o;
      end
   end

   assign sram_req      = narrow_gnt_o | wide_gnt_o;
   assign sram_bank_req = wide_gnt_o ? wide_bank_i : narrow_bank_i;
   assign wide_rvalid_o = wide_rvalid_q;

   sram_bank #(
      .WordsPerBank(WordsPerBank)
   ) i_sram_bank (
      .clk_i  (clk_i),
      .req_i  (sram_req),
      .bank_i (sram_bank_req),
      .rdata_o(rdata_o)
   );

endmodule

`default_nettype wire

// File: narrow_router.sv
//##########################################################
// Narrow router
// Steers narrow accesses to one sub-bank, fixed latency reply
//##########################################################
`timescale 1ns/1ps
`default_nettype none

module narrow_router (
   input  wire logic                            clk_i,
   input  wire logic                            rst_ni,
   input  wire logic                            req_i,
   output      logic                            gnt_o,
   input  wire mem_island_bus_pkg::narrow_req_t req_data_i,
   output      logic                            rvalid_o,
   output      mem_island_bus_pkg::narrow_data_t rdata_o,
   output      logic [mem_island_cfg_pkg::NumWideBanks-1:0]
                     [mem_island_cfg_pkg::SubBanksPerWide-1:0] bank_req_o,
   output      mem_island_bus_pkg::bank_req_t   bank_o,
   input  wire logic [mem_island_cfg_pkg::NumWideBanks-1:0]
                     [mem_island_cfg_pkg::SubBanksPerWide-1:0] bank_gnt_i,
   input  wire mem_island_bus_pkg::narrow_data_t [mem_island_cfg_pkg::NumWideBanks-1:0]
                     [mem_island_cfg_pkg::SubBanksPerWide-1:0] bank_rdata_i
);
   import mem_island_cfg_pkg::*;
   import mem_island_bus_pkg::*;

   wide_bank_idx_t wb, wb_q;
   sub_bank_idx_t  sb, sb_q;
   logic           valid_q;

   assign wb = req_data_i.addr[WideBankBit +: $bits(wide_bank_idx_t)];
   assign sb = req_data_i.addr[NarrowWordBit +: $bits(sub_bank_idx_t)];

   // Payload fans out to all sub-banks, only the addressed one sees req
   always_comb begin
      bank_req_o         = '0;
      bank_req_o[wb][sb] = req_i;
      bank_o.row         = row_t'(req_data_i.addr[AddrWidth-1:RowBit]);
      bank_o.we          = req_data_i.we;
      bank_o.wdata       = req_data_i.wdata;
      bank_o.strb        = req_data_i.strb;
   end

   assign gnt_o = bank_gnt_i[wb][sb];

   // Remember which sub-bank answers next cycle
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         valid_q <= 1'b0;
         wb_q    <= '0;
         sb_q    <= '0;
      end else begin
         valid_q <= req_i & gnt_o;
         if (req_i && gnt_o) begin
            wb_q <= wb;
            sb_q <= sb;
         end
      end
   end

   assign rvalid_o = valid_q;
   assign rdata_o  = bank_rdata_i[wb_q][sb_q];

endmodule

`default_nettype wire

// File: wide_splitter.sv
//##########################################################
// Wide splitter
// Splits one wide access over the two sub-banks of a wide
// bank and joins the two halves of the response
//##########################################################
`timescale 1ns/1ps
`default_nettype none

module wide_splitter (
   input  wire logic                          clk_i,
   input  wire logic                          rst_ni,
   input  wire logic                          req_i,
   output      logic                          gnt_o,
   input  wire mem_island_bus_pkg::wide_req_t req_data_i,
   output      logic                          rvalid_o,
   input  wire logic                          rready_i,
   output      mem_island_bus_pkg::wide_data_t rdata_o,
   output      logic [mem_island_cfg_pkg::SubBanksPerWide-1:0] part_req_o,
   output      mem_island_bus_pkg::bank_req_t [mem_island_cfg_pkg::SubBanksPerWide-1:0] part_o,
   input  wire logic [mem_island_cfg_pkg::SubBanksPerWide-1:0] part_gnt_i,
   input  wire logic [mem_island_cfg_pkg::SubBanksPerWide-1:0] part_rvalid_i,
   input  wire mem_island_bus_pkg::narrow_data_t [mem_island_cfg_pkg::SubBanksPerWide-1:0]
                     part_rdata_i
);
   import mem_island_cfg_pkg::*;
   import mem_island_bus_pkg::*;

   localparam int unsigned StrbWidth = NarrowWidth / 8;

   logic                                      busy_q;
   logic [SubBanksPerWide-1:0]                pend_q;
   logic [SubBanksPerWide-1:0]                done_q;
   wide_req_t                                 req_q;
   narrow_data_t [SubBanksPerWide-1:0]        rdata_q;
   logic                                      accept;

   // One wide access at a time
   assign gnt_o    = ~busy_q;
   assign accept   = req_i & gnt_o;
   assign rvalid_o = busy_q & (&done_q);
   assign rdata_o  = rdata_q;

   assign part_req_o = pend_q;

   // Low half goes to sub-bank 0, high half to sub-bank 1
   always_comb begin
      for (int j = 0; j < SubBanksPerWide; j++) begin
         part_o[j].row   = row_t'(req_q.addr[AddrWidth-1:RowBit]);
         part_o[j].we    = req_q.we;
         part_o[j].wdata = req_q.wdata[j*NarrowWidth +: NarrowWidth];
         part_o[j].strb  = req_q.strb[j*StrbWidth +: StrbWidth];
      end
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         busy_q <= 1'b0;
         pend_q <= '0;
         done_q <= '0;
      end else if (accept) begin
         busy_q <= 1'b1;
         pend_q <= '1;
         done_q <= '0;
      end else begin
         // Each half keeps asking until its sub-bank grants
         pend_q <= pend_q & ~part_gnt_i;
         done_q <= done_q | part_rvalid_i;
         if (rvalid_o && rready_i) begin
            busy_q <= 1'b0;
            done_q <= '0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         req_q <= req_data_i;
      end
      for (int j = 0; j < SubBanksPerWide; j++) begin
         if (part_rvalid_i[j]) begin
            rdata_q[j] <= part_rdata_i[j];
         end
      end
   end

endmodule

`default_nettype wire

// File: wide_router.sv
//##########################################################
// Wide router
// Steers wide accesses to a wide bank and returns the
// responses in grant order
//##########################################################
`timescale 1ns/1ps
`default_nettype none

module wide_router (
   input  wire logic                          clk_i,
   input  wire logic                          rst_ni,
   input  wire logic                          req_i,
   output      logic                          gnt_o,
   input  wire mem_island_bus_pkg::wide_req_t req_data_i,
   output      logic                          rvalid_o,
   output      mem_island_bus_pkg::wide_data_t rdata_o,
   output      logic [mem_island_cfg_pkg::NumWideBanks-1:0] split_req_o,
   output      mem_island_bus_pkg::wide_req_t split_data_o,
   input  wire logic [mem_island_cfg_pkg::NumWideBanks-1:0] split_gnt_i,
   input  wire logic [mem_island_cfg_pkg::NumWideBanks-1:0] split_rvalid_i,
   output      logic [mem_island_cfg_pkg::NumWideBanks-1:0] split_rready_o,
   input  wire mem_island_bus_pkg::wide_data_t [mem_island_cfg_pkg::NumWideBanks-1:0]
                     split_rdata_i
);
   import mem_island_cfg_pkg::*;
   import mem_island_bus_pkg::*;

   localparam int unsigned PtrWidth = $clog2(WideMaxOutstanding);
   localparam int unsigned CntWidth = $clog2(WideMaxOutstanding + 1);

   wide_bank_idx_t [WideMaxOutstanding-1:0] order_q;
   logic [PtrWidth-1:0]                     wr_ptr_q, rd_ptr_q;
   logic [CntWidth-1:0]                     count_q;
   wide_bank_idx_t                          req_bank, head_bank;
   logic                                    full, empty, push, pop;

   assign req_bank  = req_data_i.addr[WideBankBit +: $bits(wide_bank_idx_t)];
   assign head_bank = order_q[rd_ptr_q];
   assign full      = (count_q == CntWidth'(WideMaxOutstanding));
   assign empty     = (count_q == '0);

   assign split_data_o = req_data_i;

   always_comb begin
      split_req_o            = '0;
      split_req_o[req_bank]  = req_i & ~full;
      // Only the oldest bank may hand back its response
      split_rready_o            = '0;
      split_rready_o[head_bank] = ~empty;
   end

   assign gnt_o    = req_i & ~full & split_gnt_i[req_bank];
   assign push     = gnt_o;
   assign rvalid_o = ~empty & split_rvalid_i[head_bank];
   assign pop      = rvalid_o;
   assign rdata_o  = split_rdata_i[head_bank];

   // Order FIFO control
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         count_q <= count_q + CntWidth'(push) - CntWidth'(pop);
      end
   end

   always_ff @(posedge clk_i) begin
      if (push) begin
         order_q[wr_ptr_q] <= req_bank;
      end
   end

endmodule

`default_nettype wire

// File: mem_island_top.sv
//##########################################################
// Memory island top
// One narrow and one wide port over four SRAM sub-banks
//##########################################################
`timescale 1ns/1ps
`default_nettype none

module mem_island_top #(
   parameter int unsigned WordsPerBank     = 64,
   parameter int unsigned WidePriorityWait = 1
) (
   input  wire logic                            clk_i,
   input  wire logic                            rst_ni,
   input  wire logic                            narrow_req_i,
   output      logic                            narrow_gnt_o,
   input  wire mem_island_bus_pkg::narrow_req_t narrow_data_i,
   output      logic                            narrow_rvalid_o,
   output      mem_island_bus_pkg::narrow_data_t narrow_rdata_o,
   input  wire logic                            wide_req_i,
   output      logic                            wide_gnt_o,
   input  wire mem_island_bus_pkg::wide_req_t   wide_data_i,
   output      logic                            wide_rvalid_o,
   output      mem_island_bus_pkg::wide_data_t  wide_rdata_o
);
   import mem_island_cfg_pkg::*;
   import mem_island_bus_pkg::*;

   // Narrow router to sub-banks
   logic [NumWideBanks-1:0][SubBanksPerWide-1:0]         nb_req, nb_gnt;
   bank_req_t                                            nb_bank;
   narrow_data_t [NumWideBanks-1:0][SubBanksPerWide-1:0] bank_rdata;

   // Wide router to splitters
   logic [NumWideBanks-1:0]       split_req, split_gnt, split_rvalid, split_rready;
   wide_req_t                     split_data;
   wide_data_t [NumWideBanks-1:0] split_rdata;

   // Splitters to sub-banks
   logic [NumWideBanks-1:0][SubBanksPerWide-1:0]      part_req, part_gnt, part_rvalid;
   bank_req_t [NumWideBanks-1:0][SubBanksPerWide-1:0] part_bank;

   narrow_router i_narrow_router (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .req_i       (narrow_req_i),
      .gnt_o       (narrow_gnt_o),
      .req_data_i  (narrow_data_i),
      .rvalid_o    (narrow_rvalid_o),
      .rdata_o     (narrow_rdata_o),
      .bank_req_o  (nb_req),
      .bank_o      (nb_bank),
      .bank_gnt_i  (nb_gnt),
      .bank_rdata_i(bank_rdata)
   );

   wide_router i_wide_router (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .req_i         (wide_req_i),
      .gnt_o         (wide_gnt_o),
      .req_data_i    (wide_data_i),
      .rvalid_o      (wide_rvalid_o),
      .rdata_o       (wide_rdata_o),
      .split_req_o   (split_req),
      .split_data_o  (split_data),
      .split_gnt_i   (split_gnt),
      .split_rvalid_i(split_rvalid),
      .split_rready_o(split_rready),
      .split_rdata_i (split_rdata)
   );

   for (genvar w = 0; w < NumWideBanks; w++) begin : gen_wide_bank
      wide_splitter i_wide_splitter (
         .clk_i        (clk_i),
         .rst_ni       (rst_ni),
         .req_i        (split_req[w]),
         .gnt_o        (split_gnt[w]),
         .req_data_i   (split_data),
         .rvalid_o     (split_rvalid[w]),
         .rready_i     (split_rready[w]),
         .rdata_o      (split_rdata[w]),
         .part_req_o   (part_req[w]),
         .part_o       (part_bank[w]),
         .part_gnt_i   (part_gnt[w]),
         .part_rvalid_i(part_rvalid[w]),
         .part_rdata_i (bank_rdata[w])
      );

      for (genvar s = 0; s < SubBanksPerWide; s++) begin : gen_sub_bank
         bank_arbiter #(
            .WordsPerBank    (WordsPerBank),
            .WidePriorityWait(WidePriorityWait)
         ) i_bank_arbiter (
            .clk_i        (clk_i),
            .rst_ni       (rst_ni),
            .narrow_req_i (nb_req[w][s]),
            .narrow_bank_i(nb_bank),
            .narrow_gnt_o (nb_gnt[w][s]),
            .wide_req_i   (part_req[w][s]),
            .wide_bank_i  (part_bank[w][s]),
            .wide_gnt_o   (part_gnt[w][s]),
            .wide_rvalid_o(part_rvalid[w][s]),
            .rdata_o      (bank_rdata[w][s])
         );
      end
   end

endmodule

`default_nettype wire

// File: mem_island_tb_assert.sv
//##########################################################
// Memory island port checks
// Concurrent assertions bound onto the top level
//##########################################################
`timescale 1ns/1ps
`default_nettype none

module mem_island_tb_assert (
   input wire logic clk_i,
   input wire logic rst_ni,
   input wire logic narrow_req_i,
   input wire logic narrow_gnt_i,
   input wire logic narrow_rvalid_i,
   input wire logic wide_req_i,
   input wire logic wide_gnt_i,
   input wire logic wide_rvalid_i
);
   // Wide grants not yet answered
   logic [2:0] wide_pend_q;

   // Assertion failures seen so far
   int unsigned fail_count = 0;

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         wide_pend_q <= '0;
      end else begin
         wide_pend_q <= wide_pend_q + 3'(wide_req_i && wide_gnt_i) - 3'(wide_rvalid_i);
      end
   end

   narrow_fixed_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
      narrow_rvalid_i == $past(narrow_req_i && narrow_gnt_i))
      else begin
         $error("narrow rvalid does not follow a narrow grant by one cycle");
         fail_count++;
      end

   quiet_after_reset: assert property (@(posedge clk_i)
      $rose(rst_ni) |-> (!narrow_rvalid_i && !wide_rvalid_i))
      else begin
         $error("rvalid raised in the first cycle after reset");
         fail_count++;
      end

   wide_rvalid_matched: assert property (@(posedge clk_i) disable iff (!rst_ni)
      wide_rvalid_i |-> (wide_pend_q != '0))
      else begin
         $error("wide rvalid without an unanswered wide grant");
         fail_count++;
      end

endmodule

bind mem_island_top mem_island_tb_assert i_tb_assert (
   .clk_i          (clk_i),
   .rst_ni         (rst_ni),
   .narrow_req_i   (narrow_req_i),
   .narrow_gnt_i   (narrow_gnt_o),
   .narrow_rvalid_i(narrow_rvalid_o),
   .wide_req_i     (wide_req_i),
   .wide_gnt_i     (wide_gnt_o),
   .wide_rvalid_i  (wide_rvalid_o)
);

`default_nettype wire

// File: mem_island_tb.sv
//##########################################################
// Memory island testbench
// Directed narrow, wide, ordering and contention tests
// against a byte-array reference model
//##########################################################
`timescale 1ns/1ps
`default_nettype none

module mem_island_tb;
   import mem_island_cfg_pkg::*;
   import mem_island_bus_pkg::*;

   localparam int unsigned ModelBytes = 1024;
   localparam int unsigned MaxCycles  = 2000;
   localparam int          WideLimit  = 20;

   logic        clk_i;
   logic        rst_ni;
   logic        narrow_req_i;
   logic        narrow_gnt_o;
   narrow_req_t narrow_data_i;
   logic        narrow_rvalid_o;
   narrow_data_t narrow_rdata_o;
   logic        wide_req_i;
   logic        wide_gnt_o;
   wide_req_t   wide_data_i;
   logic        wide_rvalid_o;
   wide_data_t  wide_rdata_o;

   // Reference model with one entry per byte address
   logic [7:0]  ref_mem [ModelBytes];
   int unsigned errors;
   int unsigned checks;
   int unsigned cycles;
   int unsigned assert_fails;

   mem_island_top dut0 (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .narrow_req_i   (narrow_req_i),
      .narrow_gnt_o   (narrow_gnt_o),
      .narrow_data_i  (narrow_data_i),
      .narrow_rvalid_o(narrow_rvalid_o),
      .narrow_rdata_o (narrow_rdata_o),
      .wide_req_i     (wide_req_i),
      .wide_gnt_o     (wide_gnt_o),
      .wide_data_i    (wide_data_i),
      .wide_rvalid_o  (wide_rvalid_o),
      .wide_rdata_o   (wide_rdata_o)
   );

   always #10 clk_i = ~clk_i;

   always @(posedge clk_i) begin
      cycles++;
      if (cycles >= MaxCycles) begin
         $display("Timeout: the tests did not finish within %0d cycles", MaxCycles);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   task automatic compare(input string name, input logic [63:0] got,
                          input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic model_write(input int base, input logic [63:0] data,
                              input logic [7:0] strb, input int nbytes);
      for (int b = 0; b < nbytes; b++) begin
         if (strb[b]) begin
            ref_mem[base + b] = data[8*b +: 8];
         end
      end
   endtask

   function automatic logic [63:0] model_read(input int base, input int nbytes);
      logic [63:0] d;
      d = '0;
      for (int b = 0; b < nbytes; b++) begin
         d[8*b +: 8] = ref_mem[base + b];
      end
      return d;
   endfunction

   // Each access starts 1 ns after a rising edge and returns at the same point
   task automatic narrow_access(input addr_t addr, input logic we,
                                input narrow_data_t wdata, input narrow_strb_t strb);
      logic [63:0] exp;
      int          base;
      base                = int'(addr & 16'h03fc);
      narrow_req_i        = 1'b1;
      narrow_data_i.addr  = addr;
      narrow_data_i.we    = we;
      narrow_data_i.wdata = wdata;
      narrow_data_i.strb  = strb;
      @(negedge clk_i);
      while (!narrow_gnt_o) begin
         @(negedge clk_i);
      end
      exp = model_read(base, 4);
      if (we) begin
         model_write(base, 64'(wdata), 8'(strb), 4);
      end
      @(posedge clk_i);
      #1;
      narrow_req_i = 1'b0;
      @(negedge clk_i);
      compare("narrow_rvalid_o", 64'(narrow_rvalid_o), 64'd1);
      if (!we) begin
         compare("narrow_rdata_o", 64'(narrow_rdata_o), exp);
      end
      @(posedge clk_i);
      #1;
   endtask

   task automatic drive_wide(input addr_t addr, input logic we,
                             input wide_data_t wdata, input wide_strb_t strb);
      wide_req_i        = 1'b1;
      wide_data_i.addr  = addr;
      wide_data_i.we    = we;
      wide_data_i.wdata = wdata;
      wide_data_i.strb  = strb;
   endtask

   task automatic wide_access(input addr_t addr, input logic we,
                              input wide_data_t wdata, input wide_strb_t strb);
      logic [63:0] exp;
      int          base;
      base = int'(addr & 16'h03f8);
      drive_wide(addr, we, wdata, strb);
      @(negedge clk_i);
      while (!wide_gnt_o) begin
         @(negedge clk_i);
      end
      exp = model_read(base, 8);
      if (we) begin
         model_write(base, wdata, strb, 8);
      end
      @(posedge clk_i);
      #1;
      wide_req_i = 1'b0;
      @(negedge clk_i);
      while (!wide_rvalid_o) begin
         @(negedge clk_i);
      end
      if (!we) begin
         compare("wide_rdata_o", wide_rdata_o, exp);
      end
      @(posedge clk_i);
      #1;
   endtask

   task automatic reset_state_test();
      repeat (3) begin
         @(negedge clk_i);
         compare("narrow_gnt_o", 64'(narrow_gnt_o), 64'd0);
         compare("narrow_rvalid_o", 64'(narrow_rvalid_o), 64'd0);
         compare("wide_gnt_o", 64'(wide_gnt_o), 64'd0);
         compare("wide_rvalid_o", 64'(wide_rvalid_o), 64'd0);
         @(posedge clk_i);
         #1;
      end
   endtask

   // Eight words cover every wide bank and sub-bank over two rows
   task automatic narrow_test();
      addr_t a;
      for (int i = 0; i < 8; i++) begin
         a = addr_t'(16'h0040 + 4 * i);
         narrow_access(a, 1'b1, $urandom, 4'hf);
         narrow_access(a, 1'b1, $urandom, narrow_strb_t'($urandom));
         narrow_access(a, 1'b0, '0, '0);
      end
      for (int i = 0; i < 8; i++) begin
         narrow_access(addr_t'(16'h0040 + 4 * i), 1'b0, '0, '0);
      end
   endtask

   task automatic wide_narrow_test();
      addr_t a;
      for (int i = 0; i < 4; i++) begin
         a = addr_t'(16'h0300 + 8 * i);
         wide_access(a, 1'b1, {$urandom, $urandom}, '1);
         narrow_access(a, 1'b0, '0, '0);
         narrow_access(a + 16'd4, 1'b0, '0, '0);
         narrow_access(a + 16'd4, 1'b1, $urandom, narrow_strb_t'($urandom));
         wide_access(a, 1'b0, '0, '0);
      end
   endtask

   task automatic wide_ordering_test();
      addr_t       addrs [8];
      logic [63:0] expq [$];
      int          issued;
      int          received;
      int          outstanding;
      // Consecutive 8-byte words alternate between the two wide banks
      for (int i = 0; i < 8; i++) begin
         addrs[i] = addr_t'(16'h0200 + 8 * i);
         wide_access(addrs[i], 1'b1, {$urandom, $urandom}, '1);
      end
      issued      = 0;
      received    = 0;
      outstanding = 0;
      drive_wide(addrs[0], 1'b0, '0, '0);
      while (received < 8) begin
         @(negedge clk_i);
         if (wide_rvalid_o) begin
            if (expq.size() == 0) begin
               errors++;
               $display("A wide response arrived with no wide read outstanding");
            end else begin
               compare("wide_rdata_o", wide_rdata_o, expq.pop_front());
            end
            received++;
            outstanding--;
         end
         if (wide_req_i && wide_gnt_o) begin
            expq.push_back(model_read(int'(addrs[issued] & 16'h03f8), 8));
            issued++;
            outstanding++;
         end
         if (outstanding > int'(WideMaxOutstanding)) begin
            errors++;
            $display("More than %0d wide reads were outstanding", WideMaxOutstanding);
         end
         @(posedge clk_i);
         #1;
         if (issued < 8) begin
            drive_wide(addrs[issued], 1'b0, '0, '0);
         end else begin
            wide_req_i = 1'b0;
         end
      end
   endtask

   // Narrow reads hammer sub-bank 0 of wide bank 0 while a wide read waits
   task automatic contention_test();
      addr_t       n_addr;
      addr_t       w_addr;
      logic [63:0] n_exp;
      logic [63:0] w_exp;
      logic        n_pend;
      logic        wide_granted;
      logic        wide_done;
      int          drops;
      int          wide_wait;
      n_addr = 16'h0140;
      w_addr = 16'h0100;
      narrow_access(n_addr, 1'b1, $urandom, 4'hf);
      wide_access(w_addr, 1'b1, {$urandom, $urandom}, '1);
      n_exp        = model_read(int'(n_addr & 16'h03fc), 4);
      w_exp        = model_read(int'(w_addr & 16'h03f8), 8);
      n_pend       = 1'b0;
      wide_granted = 1'b0;
      wide_done    = 1'b0;
      drops        = 0;
      wide_wait    = 0;
      narrow_req_i        = 1'b1;
      narrow_data_i.addr  = n_addr;
      narrow_data_i.we    = 1'b0;
      narrow_data_i.wdata = '0;
      narrow_data_i.strb  = '0;
      drive_wide(w_addr, 1'b0, '0, '0);
      while (!wide_done) begin
         @(negedge clk_i);
         compare("narrow_rvalid_o", 64'(narrow_rvalid_o), 64'(n_pend));
         if (narrow_rvalid_o) begin
            compare("narrow_rdata_o", 64'(narrow_rdata_o), n_exp);
         end
         n_pend = narrow_req_i && narrow_gnt_o;
         if (narrow_req_i && !narrow_gnt_o) begin
            drops++;
         end
         if (wide_granted) begin
            wide_wait++;
            if (wide_rvalid_o) begin
               compare("wide_rdata_o", wide_rdata_o, w_exp);
               wide_done = 1'b1;
            end else if (wide_wait > WideLimit) begin
               errors++;
               $display("The wide read waited more than %0d cycles under contention",
                        WideLimit);
               wide_done = 1'b1;
            end
         end
         if (wide_req_i && wide_gnt_o) begin
            wide_granted = 1'b1;
         end
         @(posedge clk_i);
         #1;
         if (wide_granted) begin
            wide_req_i = 1'b0;
         end
      end
      narrow_req_i = 1'b0;
      @(negedge clk_i);
      compare("narrow_rvalid_o", 64'(narrow_rvalid_o), 64'(n_pend));
      if (narrow_rvalid_o) begin
         compare("narrow_rdata_o", 64'(narrow_rdata_o), n_exp);
      end
      @(posedge clk_i);
      #1;
      if (drops == 0) begin
         errors++;
         $display("The narrow grant never dropped while the wide read was pending");
      end
   endtask

   initial begin
      void'($urandom(22626));
      clk_i         = 1'b0;
      rst_ni        = 1'b0;
      narrow_req_i  = 1'b0;
      narrow_data_i = '0;
      wide_req_i    = 1'b0;
      wide_data_i   = '0;
      errors        = 0;
      checks        = 0;
      cycles        = 0;
      assert_fails  = 0;
      repeat (2) @(posedge clk_i);
      #1;
      rst_ni = 1'b1;

      reset_state_test();
      narrow_test();
      wide_narrow_test();
      wide_ordering_test();
      contention_test();

      // Bound port assertions count their own failures
      assert_fails = dut0.i_tb_assert.fail_count;
      $display("Checks: %0d, errors: %0d, assertion failures: %0d",
               checks, errors, assert_fails);
      if (errors == 0 && assert_fails == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: src.f
mem_island_cfg_pkg.sv
mem_island_bus_pkg.sv
sram_bank.sv
bank_arbiter.sv
narrow_router.sv
wide_splitter.sv
wide_router.sv
mem_island_top.sv
mem_island_tb_assert.sv
mem_island_tb.sv
